/* hw/drive_pkg.sv */
// Drive constants: unit count, family codes and sector sizes per family.
`default_nettype none

package drive_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // drive units
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Number of drive units served. Legal values are 1 to 4.
   localparam int NDR = 2;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // drive families
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam bit FAM_GCR = 1'b0;          // 157x family.
   localparam bit FAM_MFM = 1'b1;          // 1581 family.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // sectors
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam int GCR_SECTOR_BYTES = 256;  // bytes summed per 157x sector.
   localparam int MFM_SECTOR_BYTES = 512;  // bytes summed per 1581 sector.

   localparam int SECTOR_W = 6;            // sector number width.

endpackage

`default_nettype wire

/* hw/bus_pkg.sv */
// Bus constants: parallel command fields, ROM file extension codes and ROM table size.
`default_nettype none

package bus_pkg;

   // command byte layout on the parallel bus.
   localparam int CMD_UNIT_MSB   = 7;
   localparam int CMD_UNIT_LSB   = 6;
   localparam int CMD_SECTOR_MSB = 5;

   // ROM file extensions, two ASCII characters.
   localparam logic [15:0] EXT_41 = "41";
   localparam logic [15:0] EXT_70 = "70";
   localparam logic [15:0] EXT_71 = "71";
   localparam logic [15:0] EXT_81 = "81";

   localparam int ROM_AW = 4;  // 16-byte table per family.

endpackage

`default_nettype wire

/* hw/sector_engine.sv */
// Sector engine: command capture, SD read request, byte summing and result return.
`timescale 1ns/1ps
`default_nettype none

module sector_engine #(
   parameter int SECTOR_BYTES = drive_pkg::GCR_SECTOR_BYTES
) (
   input  logic                          clk_sys,
   input  logic                          reset_i,

   // host command for this unit.
   input  logic                          cmd_stb_i,
   input  logic [drive_pkg::SECTOR_W-1:0] cmd_sector_i,

   // family ROM table entry.
   input  logic [7:0]                    rom_byte_i,

   // SD card buffer.
   input  logic                          sd_ack_i,
   input  logic [15:0]                   sd_buff_addr_i,
   input  logic [7:0]                    sd_buff_dout_i,
   input  logic                          sd_buff_wr_i,

   output logic                          sd_rd_o,
   output logic [drive_pkg::SECTOR_W-1:0] sd_sector_o,
   output logic [bus_pkg::ROM_AW-1:0]    rom_addr_o,
   output logic                          busy_o,
   output logic                          res_stb_o,
   output logic [7:0]                    res_data_o
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_REQ,
      S_XFER
   } state_t;

   localparam logic [16:0] ADDR_LIMIT = 17'(SECTOR_BYTES);

   state_t                        state_q;
   logic [drive_pkg::SECTOR_W-1:0] sector_q;
   logic [7:0]                    sum_q;

   logic accept;
   logic byte_ok;
   logic done;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // control
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign accept  = cmd_stb_i & (state_q == S_IDLE);  // busy unit drops the command.
   assign done    = (state_q == S_XFER) & ~sd_ack_i;  // acknowledge has fallen.

   // only bytes of our own transfer, inside the sector.
   assign byte_ok = (state_q != S_IDLE) & sd_ack_i & sd_buff_wr_i &
                    ({1'b0, sd_buff_addr_i} < ADDR_LIMIT);

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         state_q   <= S_IDLE;
         res_stb_o <= 1'b0;
      end else begin
         res_stb_o <= done;                            // one cycle after ack falls.
         case (state_q)
            S_IDLE: begin
               if (accept) begin
                  state_q <= S_REQ;
               end
            end
            S_REQ: begin
               if (sd_ack_i) begin
                  state_q <= S_XFER;                   // card took the request.
               end
            end
            S_XFER: begin
               if (!sd_ack_i) begin
                  state_q <= S_IDLE;
               end
            end
            default: begin
               state_q <= S_IDLE;
            end
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // datapath
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk_sys) begin
      if (accept) begin
         sector_q <= cmd_sector_i;
         sum_q    <= 8'd0;
      end else if (byte_ok) begin
         sum_q <= sum_q + sd_buff_dout_i;              // wraps mod 256.
      end
      if (done) begin
         res_data_o <= sum_q + rom_byte_i;
      end
   end

   assign sd_rd_o     = (state_q == S_REQ);            // held until ack rises.
   assign sd_sector_o = sector_q;
   assign rom_addr_o  = sector_q[bus_pkg::ROM_AW-1:0];
   assign busy_o      = (state_q != S_IDLE);

endmodule

`default_nettype wire

/* hw/drive_family.sv */
// Drive family: ROM table, command decode, sector engines and merged parallel result.
`timescale 1ns/1ps
`default_nettype none

module drive_family #(
   parameter bit FAMILY = drive_pkg::FAM_GCR
) (
   input  logic                                          clk_sys,
   input  logic [drive_pkg::NDR-1:0]                     reset_i,

   input  logic [7:0]                                    par_data_i,
   input  logic                                          par_stb_i,

   input  logic                                          rom_wr_i,
   input  logic [bus_pkg::ROM_AW-1:0]                    rom_addr_i,
   input  logic [7:0]                                    rom_data_i,

   input  logic [drive_pkg::NDR-1:0]                     sd_ack_i,
   input  logic [15:0]                                   sd_buff_addr_i,
   input  logic [7:0]                                    sd_buff_dout_i,
   input  logic                                          sd_buff_wr_i,
   output logic [drive_pkg::NDR-1:0]                     sd_rd_o,
   output logic [drive_pkg::NDR-1:0][drive_pkg::SECTOR_W-1:0] sd_sector_o,

   output logic [drive_pkg::NDR-1:0]                     busy_o,
   output logic [7:0]                                    par_data_o,
   output logic                                          par_stb_o
);

   localparam int NDR          = drive_pkg::NDR;
   localparam int UNIT_W       = bus_pkg::CMD_UNIT_MSB - bus_pkg::CMD_UNIT_LSB + 1;
   localparam int SECTOR_BYTES = (FAMILY == drive_pkg::FAM_MFM) ?
                                 drive_pkg::MFM_SECTOR_BYTES : drive_pkg::GCR_SECTOR_BYTES;

   logic [7:0]              rom_q [2**bus_pkg::ROM_AW];
   logic [UNIT_W-1:0]       cmd_unit;
   logic [NDR-1:0]          cmd_stb;
   logic [NDR-1:0][bus_pkg::ROM_AW-1:0] rom_addr;
   logic [NDR-1:0][7:0]     rom_byte;
   logic [NDR-1:0]          res_stb;
   logic [NDR-1:0][7:0]     res_data;

   always_ff @(posedge clk_sys) begin
      if (rom_wr_i) begin
         rom_q[rom_addr_i] <= rom_data_i;
      end
   end

   assign cmd_unit = par_data_i[bus_pkg::CMD_UNIT_MSB:bus_pkg::CMD_UNIT_LSB];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // one engine per unit
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   for (genvar i = 0; i < NDR; i++) begin : g_unit
      assign cmd_stb[i]  = par_stb_i & (cmd_unit == UNIT_W'(i));
      assign rom_byte[i] = rom_q[rom_addr[i]];

      sector_engine #(
         .SECTOR_BYTES (SECTOR_BYTES)
      ) i_sector_engine (
         .clk_sys        (clk_sys),
         .reset_i        (reset_i[i]),
         .cmd_stb_i      (cmd_stb[i]),
         .cmd_sector_i   (par_data_i[bus_pkg::CMD_SECTOR_MSB:0]),
         .rom_byte_i     (rom_byte[i]),
         .sd_ack_i       (sd_ack_i[i]),
         .sd_buff_addr_i (sd_buff_addr_i),
         .sd_buff_dout_i (sd_buff_dout_i),
         .sd_buff_wr_i   (sd_buff_wr_i),
         .sd_rd_o        (sd_rd_o[i]),
         .sd_sector_o    (sd_sector_o[i]),
         .rom_addr_o     (rom_addr[i]),
         .busy_o         (busy_o[i]),
         .res_stb_o      (res_stb[i]),
         .res_data_o     (res_data[i])
      );
   end

   // idle engines float high, so results combine as a wired-AND.
   always_comb begin
      par_stb_o  = 1'b1;
      par_data_o = 8'hff;
      for (int i = 0; i < NDR; i++) begin
         par_stb_o  = par_stb_o & ~res_stb[i];
         par_data_o = par_data_o & (res_stb[i] ? res_data[i] : 8'hff);
      end
   end

endmodule

`default_nettype wire

/* hw/rom_router.sv */
// ROM router: file extension decode and registered write strobes per drive family.
`timescale 1ns/1ps
`default_nettype none

module rom_router (
   input  logic        clk_sys,
   input  logic [15:0] rom_ext_i,
   input  logic        rom_wr_i,
   output logic        rom_wr_gcr_o,
   output logic        rom_wr_mfm_o
);

   logic sel_gcr;
   logic sel_mfm;

   always_comb begin
      sel_gcr = 1'b0;
      sel_mfm = 1'b0;
      case (rom_ext_i)
         bus_pkg::EXT_41,
         bus_pkg::EXT_70,
         bus_pkg::EXT_71: begin
            sel_gcr = 1'b1;                  // 1541 and 157x images.
         end
         bus_pkg::EXT_81: begin
            sel_mfm = 1'b1;
         end
         default: begin
            sel_gcr = 1'b0;                  // unknown file, write is dropped.
         end
      endcase
   end

   // one stage, matched by the address and data registers in the top level.
   always_ff @(posedge clk_sys) begin
      rom_wr_gcr_o <= rom_wr_i & sel_gcr;
      rom_wr_mfm_o <= rom_wr_i & sel_mfm;
   end

endmodule

`default_nettype wire

/* hw/drive_selector.sv */
// Drive selector top: family latches, family resets, ROM routing, output merge, SD mux.
`timescale 1ns/1ps
`default_nettype none

module drive_selector (
   input  logic                               clk_sys,
   input  logic                               reset_i,

   input  logic [drive_pkg::NDR-1:0]          img_mounted_i,
   input  logic                               img_type_i,
   input  logic [31:0]                        img_size_i,

   input  logic [15:0]                        rom_ext_i,
   input  logic [bus_pkg::ROM_AW-1:0]         rom_addr_i,
   input  logic [7:0]                         rom_data_i,
   input  logic                               rom_wr_i,

   input  logic [7:0]                         par_data_i,
   input  logic                               par_stb_i,
   output logic [7:0]                         par_data_o,
   output logic                               par_stb_o,

   input  logic                               iec_data_i,
   output logic                               iec_data_o,
   output logic [drive_pkg::NDR-1:0]          led_o,

   output logic [drive_pkg::NDR-1:0][31:0]    sd_lba_o,
   output logic [drive_pkg::NDR-1:0][5:0]     sd_blk_cnt_o,
   output logic [drive_pkg::NDR-1:0]          sd_rd_o,
   input  logic [drive_pkg::NDR-1:0]          sd_ack_i,
   input  logic [15:0]                        sd_buff_addr_i,
   input  logic [7:0]                         sd_buff_dout_i,
   input  logic                               sd_buff_wr_i
);

   localparam int NDR = drive_pkg::NDR;

   logic [NDR-1:0]                     fam_q;
   logic [NDR-1:0]                     gcr_reset;
   logic [NDR-1:0]                     mfm_reset;
   logic                               cmd_stb;
   logic                               rom_wr_gcr;
   logic                               rom_wr_mfm;
   logic [bus_pkg::ROM_AW-1:0]         rom_addr_q;
   logic [7:0]                         rom_data_q;

   logic [NDR-1:0]                     gcr_rd;
   logic [NDR-1:0]                     mfm_rd;
   logic [NDR-1:0][drive_pkg::SECTOR_W-1:0] gcr_sector;
   logic [NDR-1:0][drive_pkg::SECTOR_W-1:0] mfm_sector;
   logic [NDR-1:0]                     gcr_busy;
   logic [NDR-1:0]                     mfm_busy;
   logic [7:0]                         gcr_par;
   logic [7:0]                         mfm_par;
   logic                               gcr_stb;
   logic                               mfm_stb;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // family per unit
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         fam_q <= {NDR{drive_pkg::FAM_GCR}};
      end else begin
         for (int i = 0; i < NDR; i++) begin
            if (img_mounted_i[i] && (img_size_i != 32'd0)) begin
               fam_q[i] <= img_type_i;               // empty mounts keep the family.
            end
         end
      end
   end

   // the unused family of each unit stays in reset.
   always_comb begin
      for (int i = 0; i < NDR; i++) begin
         gcr_reset[i] = reset_i | (fam_q[i] != drive_pkg::FAM_GCR);
         mfm_reset[i] = reset_i | (fam_q[i] != drive_pkg::FAM_MFM);
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // ROM uploads
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   rom_router i_rom_router (
      .clk_sys      (clk_sys),
      .rom_ext_i    (rom_ext_i),
      .rom_wr_i     (rom_wr_i),
      .rom_wr_gcr_o (rom_wr_gcr),
      .rom_wr_mfm_o (rom_wr_mfm)
   );

   always_ff @(posedge clk_sys) begin
      rom_addr_q <= rom_addr_i;
      rom_data_q <= rom_data_i;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // families
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign cmd_stb = par_stb_i & iec_data_i;         // commands only while the data line is released.

   drive_family #(
      .FAMILY (drive_pkg::FAM_GCR)
   ) i_family_gcr (
      .clk_sys        (clk_sys),
      .reset_i        (gcr_reset),
      .par_data_i     (par_data_i),
      .par_stb_i      (cmd_stb),
      .rom_wr_i       (rom_wr_gcr),
      .rom_addr_i     (rom_addr_q),
      .rom_data_i     (rom_data_q),
      .sd_ack_i       (sd_ack_i),
      .sd_buff_addr_i (sd_buff_addr_i),
      .sd_buff_dout_i (sd_buff_dout_i),
      .sd_buff_wr_i   (sd_buff_wr_i),
      .sd_rd_o        (gcr_rd),
      .sd_sector_o    (gcr_sector),
      .busy_o         (gcr_busy),
      .par_data_o     (gcr_par),
      .par_stb_o      (gcr_stb)
   );

   drive_family #(
      .FAMILY (drive_pkg::FAM_MFM)
   ) i_family_mfm (
      .clk_sys        (clk_sys),
      .reset_i        (mfm_reset),
      .par_data_i     (par_data_i),
      .par_stb_i      (cmd_stb),
      .rom_wr_i       (rom_wr_mfm),
      .rom_addr_i     (rom_addr_q),
      .rom_data_i     (rom_data_q),
      .sd_ack_i       (sd_ack_i),
      .sd_buff_addr_i (sd_buff_addr_i),
      .sd_buff_dout_i (sd_buff_dout_i),
      .sd_buff_wr_i   (sd_buff_wr_i),
      .sd_rd_o        (mfm_rd),
      .sd_sector_o    (mfm_sector),
      .busy_o         (mfm_busy),
      .par_data_o     (mfm_par),
      .par_stb_o      (mfm_stb)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // merged outputs
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign par_stb_o  = gcr_stb & mfm_stb;
   assign par_data_o = gcr_par & mfm_par;
   assign iec_data_o = ~|gcr_busy & ~|mfm_busy;     // pulled low by any busy engine.
   assign led_o      = gcr_busy | mfm_busy;

   always_comb begin
      for (int i = 0; i < NDR; i++) begin
         if (fam_q[i] == drive_pkg::FAM_MFM) begin
            sd_rd_o[i]      = mfm_rd[i];
            sd_lba_o[i]     = 32'({mfm_sector[i], 1'b0});  // two blocks per sector.
            sd_blk_cnt_o[i] = 6'd1;
         end else begin
            sd_rd_o[i]      = gcr_rd[i];
            sd_lba_o[i]     = 32'(gcr_sector[i]);
            sd_blk_cnt_o[i] = 6'd0;
         end
      end
   end

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
// Testbench clock and reset generator.
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 4
) (
   output logic clk_sys,
   output logic reset_o
);

   initial begin
      clk_sys = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk_sys = ~clk_sys;
      end
   end

   initial begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_sys);
      @(negedge clk_sys);
      reset_o = 1'b0;                     // released away from the active edge.
   end

endmodule

`default_nettype wire

/* dv/drive_selector_tb.sv */
// Drive selector testbench: SD card model, stimulus table, result and status checks.
`timescale 1ns/1ps
`default_nettype none

module drive_selector_tb;

   localparam int NDR      = drive_pkg::NDR;
   localparam int UW       = (NDR > 1) ? $clog2(NDR) : 1;
   localparam int NTEST    = 6;
   localparam int TW       = $clog2(NTEST);
   localparam int XFER_MAX = 16 + 2 * drive_pkg::MFM_SECTOR_BYTES + 16;  // delay, two blocks.
   localparam int LIMIT    = (NTEST + 2) * XFER_MAX + 400;
   localparam logic [31:0] IMG_SIZE = 32'd174848;

   typedef struct packed {
      logic [UW-1:0] unit;
      logic          fam;
      logic [5:0]    sector;
      logic [31:0]   lba;
      logic [5:0]    blk;
   } entry_t;

   // unit, family, sector, expected LBA, expected block count.
   localparam entry_t TABLE [NTEST] = '{
      '{UW'(0), drive_pkg::FAM_GCR, 6'd5,  32'd5,   6'd0},
      '{UW'(1), drive_pkg::FAM_MFM, 6'd9,  32'd18,  6'd1},
      '{UW'(0), drive_pkg::FAM_MFM, 6'd63, 32'd126, 6'd1},
      '{UW'(1), drive_pkg::FAM_GCR, 6'd20, 32'd20,  6'd0},
      '{UW'(0), drive_pkg::FAM_GCR, 6'd0,  32'd0,   6'd0},
      '{UW'(1), drive_pkg::FAM_MFM, 6'd33, 32'd66,  6'd1}
   };

   logic                 clk_sys;
   logic                 reset_i;
   logic [NDR-1:0]       img_mounted_i;
   logic                 img_type_i;
   logic [31:0]          img_size_i;
   logic [15:0]          rom_ext_i;
   logic [3:0]           rom_addr_i;
   logic [7:0]           rom_data_i;
   logic                 rom_wr_i;
   logic [7:0]           par_data_i;
   logic                 par_stb_i;
   logic [7:0]           par_data_o;
   logic                 par_stb_o;
   logic                 iec_data_i;
   logic                 iec_data_o;
   logic [NDR-1:0]       led_o;
   logic [NDR-1:0][31:0] sd_lba_o;
   logic [NDR-1:0][5:0]  sd_blk_cnt_o;
   logic [NDR-1:0]       sd_rd_o;
   logic [NDR-1:0]       sd_ack_i;
   logic [15:0]          sd_buff_addr_i;
   logic [7:0]           sd_buff_dout_i;
   logic                 sd_buff_wr_i;

   int          seed;
   int          errors  = 0;
   int          checks  = 0;
   int          strobes = 0;
   int          cycles  = 0;
   logic [7:0]  rom_gcr_exp [16];
   logic [7:0]  rom_mfm_exp [16];
   logic [31:0] seen_lba [NDR];
   logic [5:0]  seen_blk [NDR];

   tb_clock i_tb_clock (
      .clk_sys (clk_sys),
      .reset_o (reset_i)
   );

   drive_selector i_drive_selector (
      .clk_sys        (clk_sys),
      .reset_i        (reset_i),
      .img_mounted_i  (img_mounted_i),
      .img_type_i     (img_type_i),
      .img_size_i     (img_size_i),
      .rom_ext_i      (rom_ext_i),
      .rom_addr_i     (rom_addr_i),
      .rom_data_i     (rom_data_i),
      .rom_wr_i       (rom_wr_i),
      .par_data_i     (par_data_i),
      .par_stb_i      (par_stb_i),
      .par_data_o     (par_data_o),
      .par_stb_o      (par_stb_o),
      .iec_data_i     (iec_data_i),
      .iec_data_o     (iec_data_o),
      .led_o          (led_o),
      .sd_lba_o       (sd_lba_o),
      .sd_blk_cnt_o   (sd_blk_cnt_o),
      .sd_rd_o        (sd_rd_o),
      .sd_ack_i       (sd_ack_i),
      .sd_buff_addr_i (sd_buff_addr_i),
      .sd_buff_dout_i (sd_buff_dout_i),
      .sd_buff_wr_i   (sd_buff_wr_i)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // helpers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks = checks + 1;
      if (got !== exp) begin
         errors = errors + 1;
         $display("[FAIL] %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic finish_run(input bit timed_out);
      $display("checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
      if (errors == 0 && !timed_out) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   endtask

   // byte i of a transfer is (i + lba) mod 256, summed over the family's sector size.
   function automatic logic [7:0] expected_result(input logic fam, input logic [5:0] sector);
      int         lba;
      int         nbytes;
      int         a;
      logic [7:0] sum;
      lba    = fam ? 2 * int'(sector) : int'(sector);
      nbytes = fam ? drive_pkg::MFM_SECTOR_BYTES : drive_pkg::GCR_SECTOR_BYTES;
      sum    = fam ? rom_mfm_exp[sector[3:0]] : rom_gcr_exp[sector[3:0]];
      for (a = 0; a < nbytes; a++) begin
         sum = sum + 8'(a + lba);
      end
      return sum;
   endfunction

   task automatic write_rom(input logic [15:0] ext, input logic [3:0] addr,
                            input logic [7:0] data);
      @(negedge clk_sys);
      rom_ext_i  = ext;
      rom_addr_i = addr;
      rom_data_i = data;
      rom_wr_i   = 1'b1;
      @(negedge clk_sys);
      rom_wr_i   = 1'b0;
   endtask

   task automatic mount_image(input logic [UW-1:0] unit, input logic fam);
      @(negedge clk_sys);
      img_mounted_i = NDR'(1) << unit;
      img_type_i    = fam;
      img_size_i    = IMG_SIZE;
      @(negedge clk_sys);
      img_mounted_i = '0;
      img_size_i    = 32'd0;
   endtask

   task automatic send_command(input logic [UW-1:0] unit, input logic [5:0] sector);
      @(negedge clk_sys);
      par_data_i = {2'(unit), sector};
      par_stb_i  = 1'b1;
      @(negedge clk_sys);
      par_stb_i  = 1'b0;
   endtask

   task automatic wait_result(output logic [7:0] data);
      do begin
         @(negedge clk_sys);
      end while (par_stb_o !== 1'b0);
      data = par_data_o;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // SD card model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial begin : sd_card_model
      logic [UW-1:0] unit;
      logic          found;
      logic [31:0]   lba;
      int            nbytes;
      int            delay;
      int            k;
      int            a;
      seed           = 15;
      sd_ack_i       = '0;
      sd_buff_addr_i = 16'd0;
      sd_buff_dout_i = 8'd0;
      sd_buff_wr_i   = 1'b0;
      forever begin
         @(negedge clk_sys);
         found = 1'b0;
         unit  = '0;
         for (k = NDR - 1; k >= 0; k--) begin
            if (sd_rd_o[UW'(k)] === 1'b1) begin
               found = 1'b1;                     // lowest requesting unit wins.
               unit  = UW'(k);
            end
         end
         if (found) begin
            lba            = sd_lba_o[unit];
            seen_lba[unit] = lba;
            seen_blk[unit] = sd_blk_cnt_o[unit];
            nbytes         = 512 * (int'(sd_blk_cnt_o[unit]) + 1);
            delay          = int'($unsigned($random(seed)) % 32'd16);
            repeat (delay) @(negedge clk_sys);
            sd_ack_i = NDR'(1) << unit;
            for (a = 0; a < nbytes; a++) begin
               @(negedge clk_sys);
               sd_buff_addr_i = 16'(a);
               sd_buff_dout_i = 8'(a + int'(lba));
               sd_buff_wr_i   = 1'b1;
            end
            @(negedge clk_sys);
            sd_buff_wr_i = 1'b0;
            sd_ack_i     = '0;
         end
      end
   end

   always @(negedge clk_sys) begin
      if (reset_i == 1'b0 && par_stb_o == 1'b0) begin
         strobes = strobes + 1;
      end
   end

   always @(posedge clk_sys) begin
      cycles = cycles + 1;
      if (cycles >= LIMIT) begin
         $display("timeout: the DUT gave no result within %0d cycles", LIMIT);
         finish_run(1'b1);
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stimulus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial begin : main
      entry_t     e;
      logic [7:0] res;
      logic [7:0] res_b;
      int         t;
      img_mounted_i = '0;
      img_type_i    = 1'b0;
      img_size_i    = 32'd0;
      rom_ext_i     = 16'd0;
      rom_addr_i    = 4'd0;
      rom_data_i    = 8'd0;
      rom_wr_i      = 1'b0;
      par_data_i    = 8'd0;
      par_stb_i     = 1'b0;
      iec_data_i    = 1'b1;                        // host keeps the data line released.
      for (t = 0; t < 16; t++) begin
         rom_gcr_exp[4'(t)] = 8'(t * 37 + 11);
         rom_mfm_exp[4'(t)] = 8'(t * 91 + 200);
      end

      wait (reset_i == 1'b0);
      @(negedge clk_sys);
      check_value("sd_rd_o", 32'(sd_rd_o), 32'd0);
      check_value("led_o", 32'(led_o), 32'd0);
      check_value("iec_data_o", 32'(iec_data_o), 32'd1);
      check_value("par_stb_o", 32'(par_stb_o), 32'd1);
      check_value("sd_blk_cnt_o", 32'(sd_blk_cnt_o), 32'd0);

      for (t = 0; t < 16; t++) begin
         write_rom(bus_pkg::EXT_71, 4'(t), rom_gcr_exp[4'(t)]);
         write_rom(bus_pkg::EXT_81, 4'(t), rom_mfm_exp[4'(t)]);
         write_rom("64", 4'(t), 8'hee);            // no drive ROM, must be dropped.
      end

      for (t = 0; t < NTEST; t++) begin
         e = TABLE[TW'(t)];
         mount_image(e.unit, e.fam);
         send_command(e.unit, e.sector);
         check_value("led_o", 32'(led_o), 32'(NDR'(1) << e.unit));
         check_value("iec_data_o", 32'(iec_data_o), 32'd0);
         wait_result(res);
         check_value("par_data_o", 32'(res), 32'(expected_result(e.fam, e.sector)));
         check_value("sd_lba_o", seen_lba[e.unit], e.lba);
         check_value("sd_blk_cnt_o", 32'(seen_blk[e.unit]), 32'(e.blk));
         @(negedge clk_sys);
         check_value("led_o", 32'(led_o), 32'd0);
         check_value("iec_data_o", 32'(iec_data_o), 32'd1);
         check_value("par_stb_o", 32'(par_stb_o), 32'd1);
      end

      // two units in flight, then a command to a busy unit.
      mount_image(UW'(0), drive_pkg::FAM_GCR);
      mount_image(UW'(1), drive_pkg::FAM_MFM);
      send_command(UW'(0), 6'd12);
      send_command(UW'(1), 6'd40);
      send_command(UW'(0), 6'd3);
      check_value("led_o", 32'(led_o), 32'({NDR{1'b1}}));
      check_value("iec_data_o", 32'(iec_data_o), 32'd0);
      wait_result(res);
      wait_result(res_b);
      check_value("par_data_o", 32'(res), 32'(expected_result(drive_pkg::FAM_GCR, 6'd12)));
      check_value("par_data_o", 32'(res_b), 32'(expected_result(drive_pkg::FAM_MFM, 6'd40)));
      repeat (32) @(negedge clk_sys);
      check_value("led_o", 32'(led_o), 32'd0);
      check_value("sd_rd_o", 32'(sd_rd_o), 32'd0);
      check_value("par_stb_o strobe count", 32'(strobes), 32'(NTEST + 2));

      finish_run(1'b0);
   end

endmodule

`default_nettype wire

/* verilog.f */
hw/drive_pkg.sv
hw/bus_pkg.sv
hw/sector_engine.sv
hw/drive_family.sv
hw/rom_router.sv
hw/drive_selector.sv
dv/tb_clock.sv
dv/drive_selector_tb.sv

/* Makefile */
# Verilator build and run of the drive selector testbench.

TOP := drive_selector_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
